// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_cpu
FILELIST  := files.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
hdl/cpu_pkg.sv
hdl/stage_queue.sv
hdl/regfile.sv
hdl/instr_fetch.sv
hdl/instr_decode.sv
hdl/execute.sv
hdl/cpu.sv
verification/tb_instr_mem.sv
verification/tb_cpu.sv

// File: hdl/cpu.sv
module cpu (
  input  logic              clk,
  input  logic              rst,
  // Instruction memory port.
  output logic              mem_req_valid,
  input  logic              mem_req_ready,
  output cpu_pkg::word_t    mem_req_addr,
  input  logic              mem_resp_valid,
  output logic              mem_resp_ready,
  input  cpu_pkg::word_t    mem_resp_data,
  // Retired instructions.
  output logic              commit_valid,
  output cpu_pkg::word_t    commit_pc,
  output cpu_pkg::reg_idx_t commit_rd,
  output cpu_pkg::word_t    commit_value
);

  logic                    if_fetched_valid;
  logic                    if_fetched_ready;
  cpu_pkg::fetched_instr_t if_fetched_data;
  logic                    id_fetched_valid;
  logic                    id_fetched_ready;
  cpu_pkg::fetched_instr_t id_fetched_data;

  logic                    id_decoded_valid;
  logic                    id_decoded_ready;
  cpu_pkg::decoded_instr_t id_decoded_data;
  logic                    ex_decoded_valid;
  logic                    ex_decoded_ready;
  cpu_pkg::decoded_instr_t ex_decoded_data;

  logic                    ex_result_valid;
  logic                    ex_result_ready;
  cpu_pkg::exec_result_t   ex_result_data;
  cpu_pkg::exec_result_t   commit_data;

  cpu_pkg::reg_idx_t       rs1_idx;
  cpu_pkg::reg_idx_t       rs2_idx;
  cpu_pkg::word_t          rs1_val;
  cpu_pkg::word_t          rs2_val;

  instr_fetch if_inst (
    .clk            (clk),
    .rst            (rst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .mem_resp_data  (mem_resp_data),
    .fetched_valid  (if_fetched_valid),
    .fetched_ready  (if_fetched_ready),
    .fetched_data   (if_fetched_data)
  );

  stage_queue #(
    .payload_t (cpu_pkg::fetched_instr_t),
    .depth     (cpu_pkg::queue_depth)
  ) if_id_queue (
    .clk       (clk),
    .rst       (rst),
    .enq_valid (if_fetched_valid),
    .enq_ready (if_fetched_ready),
    .enq_data  (if_fetched_data),
    .deq_valid (id_fetched_valid),
    .deq_ready (id_fetched_ready),
    .deq_data  (id_fetched_data)
  );

  instr_decode id_inst (
    .clk           (clk),
    .rst           (rst),
    .fetched_valid (id_fetched_valid),
    .fetched_ready (id_fetched_ready),
    .fetched_data  (id_fetched_data),
    .decoded_valid (id_decoded_valid),
    .decoded_ready (id_decoded_ready),
    .decoded_data  (id_decoded_data),
    .rs1_idx       (rs1_idx),
    .rs2_idx       (rs2_idx),
    .rs1_val       (rs1_val),
    .rs2_val       (rs2_val),
    .commit_valid  (commit_valid),
    .commit_rd     (commit_rd)
  );

  stage_queue #(
    .payload_t (cpu_pkg::decoded_instr_t),
    .depth     (cpu_pkg::queue_depth)
  ) id_ex_queue (
    .clk       (clk),
    .rst       (rst),
    .enq_valid (id_decoded_valid),
    .enq_ready (id_decoded_ready),
    .enq_data  (id_decoded_data),
    .deq_valid (ex_decoded_valid),
    .deq_ready (ex_decoded_ready),
    .deq_data  (ex_decoded_data)
  );

  execute ex_inst (
    .decoded_valid (ex_decoded_valid),
    .decoded_ready (ex_decoded_ready),
    .decoded_data  (ex_decoded_data),
    .result_valid  (ex_result_valid),
    .result_ready  (ex_result_ready),
    .result_data   (ex_result_data)
  );

  // Commit never stalls.
  stage_queue #(
    .payload_t (cpu_pkg::exec_result_t),
    .depth     (cpu_pkg::queue_depth)
  ) ex_commit_queue (
    .clk       (clk),
    .rst       (rst),
    .enq_valid (ex_result_valid),
    .enq_ready (ex_result_ready),
    .enq_data  (ex_result_data),
    .deq_valid (commit_valid),
    .deq_ready (1'b1),
    .deq_data  (commit_data)
  );

  assign commit_pc    = commit_data.pc;
  assign commit_rd    = commit_data.rd;
  assign commit_value = commit_data.rd_val;

  regfile regfile_inst (
    .clk     (clk),
    .rst     (rst),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wr_en   (commit_valid && (commit_rd != '0)),
    .wr_idx  (commit_rd),
    .wr_data (commit_value)
  );

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

  // Machine word width for data and addresses.
  localparam int xlen = 32;

  // First instruction address after reset.
  localparam logic [xlen-1:0] boot_vec = 32'h8000_0000;

  // Number of entries held by every stage queue.
  localparam int queue_depth = 2;

  // Major opcodes handled by the core.
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // ALU operations. Pass b is used by LUI.
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetched_instr_t;

  typedef struct packed {
    word_t    pc;
    alu_op_t  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    reg_idx_t rd;
    logic     writes_rd;
  } decoded_instr_t;

  // rd is zero for instructions that write nothing.
  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    rd_val;
  } exec_result_t;

endpackage

// File: hdl/execute.sv
module execute (
  input  logic                    decoded_valid,
  output logic                    decoded_ready,
  input  cpu_pkg::decoded_instr_t decoded_data,
  output logic                    result_valid,
  input  logic                    result_ready,
  output cpu_pkg::exec_result_t   result_data
);

  cpu_pkg::word_t a;
  cpu_pkg::word_t b;
  logic [4:0]     shamt;
  cpu_pkg::word_t alu_out;

  assign a     = decoded_data.operand_a;
  assign b     = decoded_data.operand_b;
  assign shamt = b[4:0];

  always_comb begin
    case (decoded_data.alu_op)
      cpu_pkg::alu_add:    alu_out = a + b;
      cpu_pkg::alu_sub:    alu_out = a - b;
      cpu_pkg::alu_and:    alu_out = a & b;
      cpu_pkg::alu_or:     alu_out = a | b;
      cpu_pkg::alu_xor:    alu_out = a ^ b;
      cpu_pkg::alu_slt:    alu_out = {31'b0, $signed(a) < $signed(b)};
      cpu_pkg::alu_sltu:   alu_out = {31'b0, a < b};
      cpu_pkg::alu_sll:    alu_out = a << shamt;
      cpu_pkg::alu_srl:    alu_out = a >> shamt;
      cpu_pkg::alu_sra:    alu_out = $unsigned($signed(a) >>> shamt);
      cpu_pkg::alu_pass_b: alu_out = b;
      default:             alu_out = '0;
    endcase
  end

  // Single cycle, so the handshake passes straight through.
  assign result_valid  = decoded_valid;
  assign decoded_ready = result_ready;

  // No-ops retire with rd and value both zero.
  always_comb begin
    result_data.pc = decoded_data.pc;
    if (decoded_data.writes_rd) begin
      result_data.rd     = decoded_data.rd;
      result_data.rd_val = alu_out;
    end else begin
      result_data.rd     = '0;
      result_data.rd_val = '0;
    end
  end

endmodule

// File: hdl/instr_decode.sv
module instr_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetched_valid,
  output logic                    fetched_ready,
  input  cpu_pkg::fetched_instr_t fetched_data,
  output logic                    decoded_valid,
  input  logic                    decoded_ready,
  output cpu_pkg::decoded_instr_t decoded_data,
  // Register file read port.
  output cpu_pkg::reg_idx_t       rs1_idx,
  output cpu_pkg::reg_idx_t       rs2_idx,
  input  cpu_pkg::word_t          rs1_val,
  input  cpu_pkg::word_t          rs2_val,
  // Retirement clears the destination's busy bit.
  input  logic                    commit_valid,
  input  cpu_pkg::reg_idx_t       commit_rd
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  cpu_pkg::reg_idx_t rd;
  cpu_pkg::word_t    imm_i;
  cpu_pkg::word_t    imm_u;
  cpu_pkg::alu_op_t  alu_op;
  logic              legal;
  logic              uses_rs1;
  logic              uses_rs2;
  logic              writes_rd;
  logic [31:0]       busy;
  logic [31:0]       busy_now;
  logic [31:0]       clr_mask;
  logic [31:0]       set_mask;
  logic              stall;

  assign opcode  = fetched_data.instr[6:0];
  assign rd      = fetched_data.instr[11:7];
  assign funct3  = fetched_data.instr[14:12];
  assign rs1_idx = fetched_data.instr[19:15];
  assign rs2_idx = fetched_data.instr[24:20];
  assign funct7  = fetched_data.instr[31:25];

  assign imm_i = {{20{fetched_data.instr[31]}}, fetched_data.instr[31:20]};
  assign imm_u = {fetched_data.instr[31:12], 12'b0};

  always_comb begin
    alu_op   = cpu_pkg::alu_add;
    legal    = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    if (opcode == cpu_pkg::opcode_op) begin
      uses_rs1 = 1'b1;
      uses_rs2 = 1'b1;
      legal    = (funct7 == 7'b0000000) ||
                 ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      case (funct3)
        3'b000: alu_op = funct7[5] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
        3'b001: alu_op = cpu_pkg::alu_sll;
        3'b010: alu_op = cpu_pkg::alu_slt;
        3'b011: alu_op = cpu_pkg::alu_sltu;
        3'b100: alu_op = cpu_pkg::alu_xor;
        3'b101: alu_op = funct7[5] ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
        3'b110: alu_op = cpu_pkg::alu_or;
        default: alu_op = cpu_pkg::alu_and;
      endcase
    end else if (opcode == cpu_pkg::opcode_op_imm) begin
      uses_rs1 = 1'b1;
      legal    = 1'b1;
      case (funct3)
        3'b000: alu_op = cpu_pkg::alu_add;
        3'b010: alu_op = cpu_pkg::alu_slt;
        3'b011: alu_op = cpu_pkg::alu_sltu;
        3'b100: alu_op = cpu_pkg::alu_xor;
        3'b110: alu_op = cpu_pkg::alu_or;
        3'b111: alu_op = cpu_pkg::alu_and;
        3'b001: begin
          alu_op = cpu_pkg::alu_sll;
          legal  = (funct7 == 7'b0000000);
        end
        default: begin
          alu_op = funct7[5] ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
          legal  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
      endcase
    end else if (opcode == cpu_pkg::opcode_lui) begin
      alu_op = cpu_pkg::alu_pass_b;
      legal  = 1'b1;
    end
  end

  // Unsupported encodings and writes to x0 retire as no-ops.
  assign writes_rd = legal && (rd != '0);

  // A bit cleared by this cycle's commit is already free, since the register
  // file forwards the commit write.
  assign clr_mask = commit_valid ? (32'd1 << commit_rd) : '0;
  assign busy_now = busy & ~clr_mask;

  assign stall = (legal && uses_rs1 && busy_now[rs1_idx]) ||
                 (legal && uses_rs2 && busy_now[rs2_idx]) ||
                 (writes_rd && busy_now[rd]);

  assign decoded_valid = fetched_valid && !stall;
  assign fetched_ready = decoded_ready && !stall;

  always_comb begin
    decoded_data.pc        = fetched_data.pc;
    decoded_data.alu_op    = alu_op;
    decoded_data.operand_a = uses_rs1 ? rs1_val : '0;
    decoded_data.operand_b = (opcode == cpu_pkg::opcode_lui) ? imm_u :
                             uses_rs2 ? rs2_val : imm_i;
    decoded_data.rd        = rd;
    decoded_data.writes_rd = writes_rd;
  end

  // Set wins over a clear of the same register.
  assign set_mask = (decoded_valid && decoded_ready && writes_rd) ? (32'd1 << rd) : '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= '0;
    end else begin
      busy <= busy_now | set_mask;
    end
  end

endmodule

// File: hdl/instr_fetch.sv
module instr_fetch (
  input  logic                    clk,
  input  logic                    rst,
  // Instruction memory request.
  output logic                    mem_req_valid,
  input  logic                    mem_req_ready,
  output cpu_pkg::word_t          mem_req_addr,
  // Instruction memory response.
  input  logic                    mem_resp_valid,
  output logic                    mem_resp_ready,
  input  cpu_pkg::word_t          mem_resp_data,
  // Fetched instructions towards decode.
  output logic                    fetched_valid,
  input  logic                    fetched_ready,
  output cpu_pkg::fetched_instr_t fetched_data
);

  cpu_pkg::word_t pc;
  cpu_pkg::word_t req_addr;
  logic           running;
  logic           waiting;
  logic           req_fire;
  logic           resp_fire;

  // One request in flight at a time. Nothing is issued on the first edge after reset.
  assign mem_req_valid = running && !waiting;
  assign mem_req_addr  = pc;
  assign req_fire      = mem_req_valid && mem_req_ready;

  // The response goes straight into the queue, so a full queue stalls memory.
  assign fetched_valid  = waiting && mem_resp_valid;
  assign mem_resp_ready = waiting && fetched_ready;
  assign resp_fire      = mem_resp_valid && mem_resp_ready;

  assign fetched_data = '{pc: req_addr, instr: mem_resp_data};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= cpu_pkg::boot_vec;
      req_addr <= cpu_pkg::boot_vec;
      running  <= 1'b0;
      waiting  <= 1'b0;
    end else begin
      running <= 1'b1;
      if (req_fire) begin
        req_addr <= pc;
        pc       <= pc + 32'd4;
        waiting  <= 1'b1;
      end else if (resp_fire) begin
        waiting <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/regfile.sv
module regfile (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::reg_idx_t rs1_idx,
  input  cpu_pkg::reg_idx_t rs2_idx,
  output cpu_pkg::word_t    rs1_val,
  output cpu_pkg::word_t    rs2_val,
  input  logic             wr_en,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  cpu_pkg::word_t    wr_data
);

  // Register x0 has no storage.
  cpu_pkg::word_t regs [1:31];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Reads see a write landing on the same edge.
  always_comb begin
    if (rs1_idx == '0) begin
      rs1_val = '0;
    end else if (wr_en && (wr_idx == rs1_idx)) begin
      rs1_val = wr_data;
    end else begin
      rs1_val = regs[rs1_idx];
    end
  end

  always_comb begin
    if (rs2_idx == '0) begin
      rs2_val = '0;
    end else if (wr_en && (wr_idx == rs2_idx)) begin
      rs2_val = wr_data;
    end else begin
      rs2_val = regs[rs2_idx];
    end
  end

endmodule

// File: hdl/stage_queue.sv
module stage_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     enq_valid,
  output logic     enq_ready,
  input  payload_t enq_data,
  output logic     deq_valid,
  input  logic     deq_ready,
  output payload_t deq_data
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           slots [depth];
  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w-1:0]   wr_ptr;
  logic [cnt_w-1:0]   count;
  logic               enq_fire;
  logic               deq_fire;

  // A full queue still accepts when the head leaves in the same cycle.
  assign enq_ready = (count != cnt_w'(depth)) || deq_ready;
  assign deq_valid = (count != '0);
  assign deq_data  = slots[rd_ptr];

  assign enq_fire = enq_valid && enq_ready;
  assign deq_fire = deq_valid && deq_ready;

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      slots[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves when exactly one side transfers.
      if (enq_fire && !deq_fire) begin
        count <= count + 1'b1;
      end else if (deq_fire && !enq_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: verification/tb_cpu.sv
module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_instrs = 64;
  // About 20 cycles per instruction in the worst case, plus margin.
  localparam int cycle_limit = 2000;

  logic        clk;
  logic        rst;
  logic        mem_req_valid;
  logic        mem_req_ready;
  logic [31:0] mem_req_addr;
  logic        mem_resp_valid;
  logic        mem_resp_ready;
  logic [31:0] mem_resp_data;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [4:0]  commit_rd;
  logic [31:0] commit_value;

  // Architectural state of the reference model.
  logic [31:0] xreg [32];
  logic [31:0] model_pc;
  logic [31:0] next_fetch_addr;
  logic        outstanding;
  int          commits;
  int          cycles;
  int          edges_after_reset;

  cpu cpu_i (
    .clk            (clk),
    .rst            (rst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .mem_resp_data  (mem_resp_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_rd      (commit_rd),
    .commit_value   (commit_value)
  );

  tb_instr_mem instr_mem_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (mem_req_valid),
    .req_ready  (mem_req_ready),
    .req_addr   (mem_req_addr),
    .resp_valid (mem_resp_valid),
    .resp_ready (mem_resp_ready),
    .resp_data  (mem_resp_data)
  );

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED at %0t: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  // RV32I semantics for the integer subset. Anything else retires as a no-op.
  function automatic void reference_exec(input logic [31:0] instr,
                                         output logic [4:0] exp_rd,
                                         output logic [31:0] exp_val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] val;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    a   = xreg[instr[19:15]];
    b   = xreg[instr[24:20]];
    imm = {{20{instr[31]}}, instr[31:20]};
    f3  = instr[14:12];
    f7  = instr[31:25];
    ok  = 1'b1;
    val = '0;
    case (instr[6:0])
      7'b0110011: begin
        case ({f7, f3})
          {7'h00, 3'd0}: val = a + b;
          {7'h20, 3'd0}: val = a - b;
          {7'h00, 3'd1}: val = a << b[4:0];
          {7'h00, 3'd2}: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          {7'h00, 3'd3}: val = (a < b) ? 32'd1 : 32'd0;
          {7'h00, 3'd4}: val = a ^ b;
          {7'h00, 3'd5}: val = a >> b[4:0];
          {7'h20, 3'd5}: val = $signed(a) >>> b[4:0];
          {7'h00, 3'd6}: val = a | b;
          {7'h00, 3'd7}: val = a & b;
          default:       ok = 1'b0;
        endcase
      end
      7'b0010011: begin
        case (f3)
          3'd0: val = a + imm;
          3'd2: val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          3'd3: val = (a < imm) ? 32'd1 : 32'd0;
          3'd4: val = a ^ imm;
          3'd6: val = a | imm;
          3'd7: val = a & imm;
          3'd1: begin
            ok  = (f7 == 7'h00);
            val = a << instr[24:20];
          end
          default: begin
            ok = (f7 == 7'h00) || (f7 == 7'h20);
            if (f7[5]) begin
              val = $signed(a) >>> instr[24:20];
            end else begin
              val = a >> instr[24:20];
            end
          end
        endcase
      end
      7'b0110111: val = {instr[31:12], 12'b0};
      default:    ok = 1'b0;
    endcase
    if (ok && (instr[11:7] != 5'd0)) begin
      exp_rd  = instr[11:7];
      exp_val = val;
    end else begin
      exp_rd  = 5'd0;
      exp_val = '0;
    end
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst               = 1'b1;
    model_pc          = cpu_pkg::boot_vec;
    next_fetch_addr   = cpu_pkg::boot_vec;
    outstanding       = 1'b0;
    commits           = 0;
    cycles            = 0;
    edges_after_reset = 0;
    for (int i = 0; i < 32; i++) begin
      xreg[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rst) begin
      edges_after_reset <= edges_after_reset + 1;
    end
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d instructions committed",
               cycles, commits, num_instrs);
      abort_run();
    end
  end

  // Inputs change on rising edges only, so the falling edge sees settled values.
  always @(negedge clk) begin
    logic [4:0]  exp_rd;
    logic [31:0] exp_val;
    if (rst || (edges_after_reset == 0)) begin
      check_value("mem_req_valid", 32'd0, 32'(mem_req_valid));
      check_value("commit_valid", 32'd0, 32'(commit_valid));
    end
    if (!rst) begin
      if (mem_req_valid && mem_req_ready) begin
        assert (!outstanding) else begin
          $display("a second request was accepted at %0t before the previous response", $time);
          abort_run();
        end
        check_value("mem_req_addr", next_fetch_addr, mem_req_addr);
        next_fetch_addr = next_fetch_addr + 32'd4;
        outstanding     = 1'b1;
      end else if (mem_resp_valid && mem_resp_ready) begin
        outstanding = 1'b0;
      end
      if (commit_valid) begin
        reference_exec(instr_mem_i.prog[commits[5:0]], exp_rd, exp_val);
        check_value("commit_pc", model_pc, commit_pc);
        check_value("commit_rd", 32'(exp_rd), 32'(commit_rd));
        check_value("commit_value", exp_val, commit_value);
        if (exp_rd != 5'd0) begin
          xreg[exp_rd] = exp_val;
        end
        model_pc = model_pc + 32'd4;
        commits  = commits + 1;
        if (commits == num_instrs) begin
          $display("test passed");
          $finish;
        end
      end
    end
  end

endmodule

// File: verification/tb_instr_mem.sv
module tb_instr_mem (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid,
  output logic        req_ready,
  input  logic [31:0] req_addr,
  output logic        resp_valid,
  input  logic        resp_ready,
  output logic [31:0] resp_data
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int prog_words = 64;

  logic [31:0] prog [prog_words];
  integer      seed = 32'hf4c2;
  logic [4:0]  recent [4];
  logic        pending;
  logic [1:0]  delay;
  logic [31:0] addr_q;

  // Sources lean toward the last few destinations so that hazards occur.
  function automatic logic [4:0] pick_src();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:2] != 2'b00) begin
      return recent[r[1:0]];
    end
    return r[8:4];
  endfunction

  // Past the program the core fetches ahead into NOPs.
  function automatic logic [31:0] word_at(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - cpu_pkg::boot_vec;
    if ((offset[1:0] == 2'b00) && (offset < 32'(prog_words * 4))) begin
      return prog[offset[7:2]];
    end
    return 32'h0000_0013;
  endfunction

  initial begin
    logic [31:0] r;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    req_ready  = 1'b0;
    resp_valid = 1'b0;
    resp_data  = '0;
    pending    = 1'b0;
    delay      = '0;
    addr_q     = '0;
    for (int i = 0; i < 4; i++) begin
      recent[i] = 5'(i + 1);
    end
    for (int i = 0; i < prog_words; i++) begin
      r    = $random(seed);
      kind = r[3:0];
      rd   = r[8:4];
      f3   = r[11:9];
      f7   = (r[12] && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'b0100000 : 7'b0000000;
      rs1  = pick_src();
      rs2  = pick_src();
      // Kind 13 writes x0 and kind 15 reads x0.
      if (kind == 4'd13) begin
        rd = 5'd0;
      end
      if (kind == 4'd15) begin
        rs1 = 5'd0;
      end
      if (kind == 4'd14) begin
        // Unsupported: a load or an M extension op.
        prog[i] = r[12] ? {7'b0000001, rs2, rs1, f3, rd, cpu_pkg::opcode_op} :
                          {r[31:7], 7'b0000011};
      end else if ((kind >= 4'd6) && (kind <= 4'd10)) begin
        if ((f3 == 3'b001) || (f3 == 3'b101)) begin
          prog[i] = {f7, r[17:13], rs1, f3, rd, cpu_pkg::opcode_op_imm};
        end else begin
          prog[i] = {r[31:20], rs1, f3, rd, cpu_pkg::opcode_op_imm};
        end
      end else if ((kind == 4'd11) || (kind == 4'd12)) begin
        prog[i] = {r[31:12], rd, cpu_pkg::opcode_lui};
      end else begin
        prog[i] = {f7, rs2, rs1, f3, rd, cpu_pkg::opcode_op};
      end
      if ((kind != 4'd14) && (rd != 5'd0)) begin
        recent[3] = recent[2];
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = rd;
      end
    end
  end

  always @(posedge clk) begin
    logic [31:0] r;
    if (rst) begin
      req_ready  <= 1'b0;
      resp_valid <= 1'b0;
      pending    <= 1'b0;
    end else begin
      r = $random(seed);
      // Roughly one cycle in four refuses a request.
      req_ready <= (r[1:0] != 2'b00);
      if (resp_valid && resp_ready) begin
        resp_valid <= 1'b0;
      end
      if (req_valid && req_ready) begin
        // A zero delay answers in the cycle right after the request.
        if (r[3:2] == 2'd0) begin
          resp_valid <= 1'b1;
          resp_data  <= word_at(req_addr);
        end else begin
          pending <= 1'b1;
          addr_q  <= req_addr;
          delay   <= r[3:2] - 2'd1;
        end
      end else if (pending) begin
        if (delay == 2'd0) begin
          resp_valid <= 1'b1;
          resp_data  <= word_at(addr_q);
          pending    <= 1'b0;
        end else begin
          delay <= delay - 1'b1;
        end
      end
    end
  end

endmodule
